// File: design/ddr_test_pkg.sv
// shared types, seeds and sequencer states, imported by every rtl block of the traffic generator
`default_nettype none

package ddr_test_pkg;

  // --------------------
  // data path widths
  // --------------------
  typedef logic [31:0] data_t;
  typedef logic [7:0]  lane_t;
  typedef logic [3:0]  be_t;

  // --------------------
  // address fields
  // --------------------
  typedef logic [8:0]  col_t;
  typedef logic [12:0] row_t;
  typedef logic [1:0]  bank_t;

  // outstanding request count
  typedef logic [7:0]  count_t;

  localparam int NUM_LANES = 4;

  // lane lfsr seeds
  localparam lane_t LANE_SEED_0 = 8'd1;
  localparam lane_t LANE_SEED_1 = 8'd11;
  localparam lane_t LANE_SEED_2 = 8'd21;
  localparam lane_t LANE_SEED_3 = 8'd31;

  // two columns per local word
  localparam col_t COL_STEP = 9'd2;

  typedef enum logic [3:0] {
    IDLE,
    START,
    WRITE,
    WRITE_DRAIN,
    REWRITE_PREP,
    READ_PREP,
    READ,
    READ_DRAIN,
    DONE
  } seq_state_t;

endpackage

`default_nettype wire

// File: design/lane_lfsr.sv
// 8-bit pattern lfsr for one byte lane, stepped by the pattern generator once per data beat
`timescale 1ns/100ps
`default_nettype none

module lane_lfsr #(
  parameter ddr_test_pkg::lane_t seed = 8'd1
) (
  input  wire                       clk,
  input  wire                       reset_n,
  input  wire                       enable,
  input  wire                       load,
  input  wire                       pause,
  input  wire ddr_test_pkg::lane_t  ldata,
  output ddr_test_pkg::lane_t       data
);

  import ddr_test_pkg::*;

  lane_t next_data;

  // shift left, feedback from taps 7 5 4 3
  assign next_data = {data[6:0], data[7] ^ data[5] ^ data[4] ^ data[3]};

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      data <= seed;
    end
    else if (load)
    begin
      // rewind to the captured start value
      data <= ldata;
    end
    else if (enable && !pause)
    begin
      data <= next_data;
    end
  end

endmodule

`default_nettype wire

// File: design/pattern_gen.sv
// write data, expected read data and byte enables for the traffic generator, one lfsr per lane
`timescale 1ns/100ps
`default_nettype none

module pattern_gen (
  input  wire                   clk,
  input  wire                   reset_n,
  input  wire                   write_beat,
  input  wire                   rdata_valid,
  input  wire                   rewind,
  input  wire                   capture_seed,
  input  wire                   zero_data,
  input  wire                   mask_mode,
  input  wire                   be_restart,
  output ddr_test_pkg::data_t   wdata,
  output ddr_test_pkg::data_t   expected,
  output ddr_test_pkg::be_t     be
);

  import ddr_test_pkg::*;

  wire data_t lfsr_word;
  data_t      reload_word;
  logic       lfsr_enable;
  logic       lfsr_pause;
  logic       be_rotate;

  // lfsrs hold during zero fill, step on each write beat or read word
  assign lfsr_enable = ~zero_data;
  assign lfsr_pause  = ~(write_beat | rdata_valid);

  // --------------------
  // lane generators
  // --------------------
  lane_lfsr #(.seed(LANE_SEED_0)) u_lane0 (
    .clk     (clk),
    .reset_n (reset_n),
    .enable  (lfsr_enable),
    .load    (rewind),
    .pause   (lfsr_pause),
    .ldata   (reload_word[7:0]),
    .data    (lfsr_word[7:0])
  );

  lane_lfsr #(.seed(LANE_SEED_1)) u_lane1 (
    .clk     (clk),
    .reset_n (reset_n),
    .enable  (lfsr_enable),
    .load    (rewind),
    .pause   (lfsr_pause),
    .ldata   (reload_word[15:8]),
    .data    (lfsr_word[15:8])
  );

  lane_lfsr #(.seed(LANE_SEED_2)) u_lane2 (
    .clk     (clk),
    .reset_n (reset_n),
    .enable  (lfsr_enable),
    .load    (rewind),
    .pause   (lfsr_pause),
    .ldata   (reload_word[23:16]),
    .data    (lfsr_word[23:16])
  );

  lane_lfsr #(.seed(LANE_SEED_3)) u_lane3 (
    .clk     (clk),
    .reset_n (reset_n),
    .enable  (lfsr_enable),
    .load    (rewind),
    .pause   (lfsr_pause),
    .ldata   (reload_word[31:24]),
    .data    (lfsr_word[31:24])
  );

  // word present at the first write of a pass
  always_ff @(posedge clk)
  begin
    if (capture_seed)
    begin
      reload_word <= lfsr_word;
    end
  end

  assign wdata    = zero_data ? '0 : lfsr_word;
  assign expected = lfsr_word;

  // --------------------
  // byte enables
  // --------------------
  assign be_rotate = mask_mode & ~zero_data & (write_beat | rdata_valid);

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      be <= '1;
    end
    else if (be_restart)
    begin
      be <= be_t'(1);
    end
    else if (be_rotate)
    begin
      be <= {be[2:0], be[3]};
    end
    else if (!mask_mode || zero_data)
    begin
      be <= '1;
    end
  end

endmodule

`default_nettype wire

// File: design/addr_gen.sv
// sequential column, row, bank address walk over the test window, advanced per accepted beat
`timescale 1ns/100ps
`default_nettype none

module addr_gen #(
  parameter ddr_test_pkg::col_t  max_col  = 9'd16,
  parameter ddr_test_pkg::row_t  max_row  = 13'd3,
  parameter ddr_test_pkg::bank_t max_bank = 2'd3
) (
  input  wire                   clk,
  input  wire                   reset_n,
  input  wire                   addr_step,
  input  wire                   addr_clear,
  output ddr_test_pkg::col_t    col_addr,
  output ddr_test_pkg::row_t    row_addr,
  output ddr_test_pkg::bank_t   bank_addr,
  output logic                  at_window_end
);

  import ddr_test_pkg::*;

  // last beat of the window
  assign at_window_end = (col_addr == max_col) && (row_addr == max_row) &&
                         (bank_addr == max_bank);

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      col_addr  <= '0;
      row_addr  <= '0;
      bank_addr <= '0;
    end
    else if (addr_clear)
    begin
      col_addr  <= '0;
      row_addr  <= '0;
      bank_addr <= '0;
    end
    else if (addr_step)
    begin
      if (col_addr >= max_col)
      begin
        col_addr <= '0;
        // column wrapped, carry into row then bank
        if (row_addr == max_row)
        begin
          row_addr <= '0;
          if (bank_addr == max_bank)
            bank_addr <= '0;
          else
            bank_addr <= bank_addr + 1'b1;
        end
        else
        begin
          row_addr <= row_addr + 1'b1;
        end
      end
      else
      begin
        col_addr <= col_addr + COL_STEP;
      end
    end
  end

endmodule

`default_nettype wire

// File: design/read_checker.sv
// per-lane compare of returned read data against the regenerated pattern, with pass flags
`timescale 1ns/100ps
`default_nettype none

module read_checker (
  input  wire                   clk,
  input  wire                   reset_n,
  input  wire ddr_test_pkg::data_t rdata,
  input  wire                   rdata_valid,
  input  wire ddr_test_pkg::data_t expected,
  input  wire ddr_test_pkg::be_t   be,
  output ddr_test_pkg::be_t     pnf_per_byte,
  output logic                  pnf_persist
);

  import ddr_test_pkg::*;

  be_t  lane_match;
  be_t  match_q;
  be_t  lane_pass;
  logic valid_q;
  logic seen_read;
  logic seen_read_d1;
  logic seen_read_d2;
  logic persist_pre;
  logic persist_prev;

  // disabled lanes are expected back as zero
  always_comb
  begin
    for (int i = 0; i < NUM_LANES; i++)
      lane_match[i] = (expected[8*i +: 8] & {8{be[i]}}) == rdata[8*i +: 8];
  end

  // sticky until reset once any read has returned
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
      seen_read <= 1'b0;
    else if (rdata_valid)
      seen_read <= 1'b1;
  end

  // only the very first check may start from a passing state
  assign persist_prev = seen_read_d2 ? persist_pre : 1'b1;

  // --------------------
  // result pipeline
  // --------------------
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      match_q      <= '1;
      valid_q      <= 1'b0;
      lane_pass    <= '1;
      pnf_per_byte <= '1;
      seen_read_d1 <= 1'b0;
      seen_read_d2 <= 1'b0;
      persist_pre  <= 1'b0;
      pnf_persist  <= 1'b0;
    end
    else
    begin
      match_q      <= lane_match;
      valid_q      <= rdata_valid;
      seen_read_d1 <= seen_read;
      seen_read_d2 <= seen_read_d1;
      // hold the last checked word between valids
      if (valid_q)
        lane_pass <= match_q;
      pnf_per_byte <= lane_pass;
      persist_pre  <= (&lane_pass) & seen_read_d1 & persist_prev;
      pnf_persist  <= persist_pre;
    end
  end

endmodule

`default_nettype wire

// File: design/test_sequencer.sv
// FSM that orders the write, drain and read phases of both test passes and tracks outstanding requests
`timescale 1ns/100ps
`default_nettype none

module test_sequencer (
  input  wire   clk,
  input  wire   reset_n,
  input  wire   ready,
  input  wire   rdata_valid,
  input  wire   at_window_end,
  output logic  write_req,
  output logic  read_req,
  output logic  addr_step,
  output logic  addr_clear,
  output logic  write_beat,
  output logic  rewind,
  output logic  capture_seed,
  output logic  zero_data,
  output logic  mask_mode,
  output logic  be_restart,
  output logic  seq_mode,
  output logic  test_complete
);

  import ddr_test_pkg::*;

  seq_state_t state;
  count_t     reads_pending;
  logic       write_accept;
  logic       read_accept;

  assign write_accept = write_req & ready;
  assign read_accept  = read_req & ready;
  assign write_beat   = write_accept;
  assign addr_step    = write_accept | read_accept;

  // --------------------
  // outstanding reads
  // --------------------
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      reads_pending <= '0;
    end
    else
    begin
      reads_pending <= reads_pending + count_t'(read_accept) - count_t'(rdata_valid);
    end
  end

  // --------------------
  // pass sequencing
  // --------------------
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      state         <= IDLE;
      write_req     <= 1'b0;
      read_req      <= 1'b0;
      addr_clear    <= 1'b0;
      rewind        <= 1'b0;
      capture_seed  <= 1'b0;
      zero_data     <= 1'b0;
      mask_mode     <= 1'b0;
      be_restart    <= 1'b0;
      seq_mode      <= 1'b0;
      test_complete <= 1'b0;
    end
    else
    begin
      // single-cycle strobes
      addr_clear    <= 1'b0;
      rewind        <= 1'b0;
      be_restart    <= 1'b0;
      test_complete <= 1'b0;
      case (state)
        IDLE:
        begin
          seq_mode  <= 1'b1;
          mask_mode <= 1'b0;
          state     <= START;
        end
        START:
        begin
          write_req    <= 1'b1;
          capture_seed <= 1'b1;
          // data-mask pass opens with a zero fill
          zero_data    <= mask_mode;
          state        <= WRITE;
        end
        WRITE:
        begin
          capture_seed <= 1'b0;
          if (write_accept && at_window_end)
          begin
            write_req <= 1'b0;
            state     <= WRITE_DRAIN;
          end
        end
        WRITE_DRAIN:
        begin
          addr_clear <= 1'b1;
          rewind     <= 1'b1;
          be_restart <= mask_mode;
          state      <= zero_data ? REWRITE_PREP : READ_PREP;
        end
        REWRITE_PREP:
        begin
          zero_data <= 1'b0;
          write_req <= 1'b1;
          state     <= WRITE;
        end
        READ_PREP:
        begin
          read_req <= 1'b1;
          state    <= READ;
        end
        READ:
        begin
          if (read_accept && at_window_end)
          begin
            read_req <= 1'b0;
            state    <= READ_DRAIN;
          end
        end
        READ_DRAIN:
        begin
          // every read word must be back before the next pass
          if (reads_pending == '0)
          begin
            addr_clear <= 1'b1;
            if (seq_mode)
            begin
              seq_mode  <= 1'b0;
              mask_mode <= 1'b1;
              state     <= START;
            end
            else
            begin
              mask_mode <= 1'b0;
              state     <= DONE;
            end
          end
        end
        DONE:
        begin
          test_complete <= 1'b1;
          state         <= IDLE;
        end
        default:
        begin
          state <= IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: design/ddr_test_driver.sv
// top level of the ddr traffic generator, connects the generator blocks to the controller local port
`timescale 1ns/100ps
`default_nettype none

module ddr_test_driver #(
  parameter ddr_test_pkg::col_t  max_col  = 9'd16,
  parameter ddr_test_pkg::row_t  max_row  = 13'd3,
  parameter ddr_test_pkg::bank_t max_bank = 2'd3
) (
  input  wire                       clk,
  input  wire                       reset_n,
  input  wire                       ready,
  input  wire ddr_test_pkg::data_t  rdata,
  input  wire                       rdata_valid,
  output logic                      write_req,
  output logic                      read_req,
  output ddr_test_pkg::row_t        row_addr,
  output ddr_test_pkg::col_t        col_addr,
  output ddr_test_pkg::bank_t       bank_addr,
  output ddr_test_pkg::be_t         be,
  output ddr_test_pkg::data_t       wdata,
  output ddr_test_pkg::be_t         pnf_per_byte,
  output logic                      pnf_persist,
  output logic                      test_complete,
  output logic [2:0]                test_status
);

  import ddr_test_pkg::*;

  logic  addr_step;
  logic  addr_clear;
  logic  at_window_end;
  logic  write_beat;
  logic  rewind;
  logic  capture_seed;
  logic  zero_data;
  logic  mask_mode;
  logic  be_restart;
  logic  seq_mode;
  data_t expected;

  // bit 0 sequential pass, bit 1 data-mask pass, bit 2 sequence done
  assign test_status = {test_complete, mask_mode, seq_mode};

  test_sequencer u_sequencer (
    .clk           (clk),
    .reset_n       (reset_n),
    .ready         (ready),
    .rdata_valid   (rdata_valid),
    .at_window_end (at_window_end),
    .write_req     (write_req),
    .read_req      (read_req),
    .addr_step     (addr_step),
    .addr_clear    (addr_clear),
    .write_beat    (write_beat),
    .rewind        (rewind),
    .capture_seed  (capture_seed),
    .zero_data     (zero_data),
    .mask_mode     (mask_mode),
    .be_restart    (be_restart),
    .seq_mode      (seq_mode),
    .test_complete (test_complete)
  );

  addr_gen #(
    .max_col  (max_col),
    .max_row  (max_row),
    .max_bank (max_bank)
  ) u_addr_gen (
    .clk           (clk),
    .reset_n       (reset_n),
    .addr_step     (addr_step),
    .addr_clear    (addr_clear),
    .col_addr      (col_addr),
    .row_addr      (row_addr),
    .bank_addr     (bank_addr),
    .at_window_end (at_window_end)
  );

  pattern_gen u_pattern_gen (
    .clk          (clk),
    .reset_n      (reset_n),
    .write_beat   (write_beat),
    .rdata_valid  (rdata_valid),
    .rewind       (rewind),
    .capture_seed (capture_seed),
    .zero_data    (zero_data),
    .mask_mode    (mask_mode),
    .be_restart   (be_restart),
    .wdata        (wdata),
    .expected     (expected),
    .be           (be)
  );

  read_checker u_read_checker (
    .clk          (clk),
    .reset_n      (reset_n),
    .rdata        (rdata),
    .rdata_valid  (rdata_valid),
    .expected     (expected),
    .be           (be),
    .pnf_per_byte (pnf_per_byte),
    .pnf_persist  (pnf_persist)
  );

endmodule

`default_nettype wire

// File: bench/ddr_test_driver_properties.sv
// local port protocol assertions for the ddr traffic generator, bound into its top level
`timescale 1ns/100ps
`default_nettype none

module ddr_test_driver_properties (
  input wire                       clk,
  input wire                       reset_n,
  input wire                       ready,
  input wire                       write_req,
  input wire                       read_req,
  input wire ddr_test_pkg::row_t   row_addr,
  input wire ddr_test_pkg::col_t   col_addr,
  input wire ddr_test_pkg::bank_t  bank_addr,
  input wire ddr_test_pkg::be_t    be,
  input wire ddr_test_pkg::data_t  wdata,
  input wire [2:0]                 test_status
);

  // number of failed assertions so far
  int unsigned violations = 0;

  no_dual_request: assert property (@(posedge clk) disable iff (!reset_n)
    !(write_req && read_req))
  else
  begin
    $error("write_req and read_req are high together");
    violations++;
  end

  // --------------------
  // stall behaviour
  // --------------------
  hold_request: assert property (@(posedge clk) disable iff (!reset_n)
    (write_req || read_req) && !ready |=> $stable(write_req) && $stable(read_req) &&
      $stable(row_addr) && $stable(col_addr) && $stable(bank_addr))
  else
  begin
    $error("request or address moved while ready was low");
    violations++;
  end

  hold_wdata: assert property (@(posedge clk) disable iff (!reset_n)
    write_req && !ready |=> $stable(wdata))
  else
  begin
    $error("wdata moved while ready was low");
    violations++;
  end

  // masked writes carry a single byte enable
  mask_one_hot: assert property (@(posedge clk) disable iff (!reset_n)
    test_status[1] && write_req && (wdata != '0) |-> $onehot(be))
  else
  begin
    $error("be is not one-hot on a masked write");
    violations++;
  end

endmodule

bind ddr_test_driver ddr_test_driver_properties u_properties (
  .clk         (clk),
  .reset_n     (reset_n),
  .ready       (ready),
  .write_req   (write_req),
  .read_req    (read_req),
  .row_addr    (row_addr),
  .col_addr    (col_addr),
  .bank_addr   (bank_addr),
  .be          (be),
  .wdata       (wdata),
  .test_status (test_status)
);

`default_nettype wire

// File: bench/ddr_test_driver_tb.sv
// testbench for the ddr traffic generator, models the controller local port and checks every beat
`timescale 1ns/100ps
`default_nettype none

module ddr_test_driver_tb;

  import ddr_test_pkg::*;

  localparam col_t  WIN_COL  = 9'd16;
  localparam row_t  WIN_ROW  = 13'd3;
  localparam bank_t WIN_BANK = 2'd3;
  localparam int BEATS_PER_PASS = 144;
  localparam int PHASES = 5;
  localparam int NUM_SEQUENCES = 2;
  localparam int SEQ_TIMEOUT = 4000;
  localparam int CORRUPT_BEAT = 5;
  localparam int CORRUPT_LANE = 2;
  localparam logic [31:0] SEED_WORD = {8'd31, 8'd21, 8'd11, 8'd1};

  typedef struct packed {
    logic [31:0] data;
    logic        corrupt;
    logic [31:0] due;
  } ret_t;

  logic        clk;
  logic        reset_n;
  logic        ready;
  data_t       rdata;
  logic        rdata_valid;
  logic        write_req;
  logic        read_req;
  row_t        row_addr;
  col_t        col_addr;
  bank_t       bank_addr;
  be_t         be;
  data_t       wdata;
  be_t         pnf_per_byte;
  logic        pnf_persist;
  logic        test_complete;
  logic [2:0]  test_status;

  // memory model keyed by {bank, row, col}
  logic [31:0] mem [logic [23:0]];
  ret_t        ret_q[$];
  logic        ret_corrupt;
  logic [15:0] rand_state;
  logic [31:0] cycle;
  logic [31:0] last_due;
  int          error_count;
  int          beat_idx;
  int          complete_count;
  int          ret_idx;
  int          watch_left;
  logic [23:0] exp_addr;
  logic [23:0] corrupt_key;
  logic [31:0] gen_word;
  logic [31:0] data_base;
  logic [31:0] read_word;
  logic        read_masked;
  logic        corrupt_armed;
  logic        corrupt_seen;
  logic        watching;
  logic        lane_dropped;
  logic        persist_dropped;
  logic        timed_out;

  ddr_test_driver #(
    .max_col  (WIN_COL),
    .max_row  (WIN_ROW),
    .max_bank (WIN_BANK)
  ) u_ddr_test_driver (
    .clk           (clk),
    .reset_n       (reset_n),
    .ready         (ready),
    .rdata         (rdata),
    .rdata_valid   (rdata_valid),
    .write_req     (write_req),
    .read_req      (read_req),
    .row_addr      (row_addr),
    .col_addr      (col_addr),
    .bank_addr     (bank_addr),
    .be            (be),
    .wdata         (wdata),
    .pnf_per_byte  (pnf_per_byte),
    .pnf_persist   (pnf_persist),
    .test_complete (test_complete),
    .test_status   (test_status)
  );

  always #50 clk = ~clk;

  // --------------------
  // reference models
  // --------------------
  // 16-bit galois lfsr, taps 16 14 13 11
  function automatic logic [15:0] galois_step(input logic [15:0] s);
    if (s[0])
      return (s >> 1) ^ 16'hB400;
    else
      return s >> 1;
  endfunction

  task automatic random_bits(input int n, output logic [7:0] value);
    value = '0;
    for (int i = 0; i < n; i++)
    begin
      value = {value[6:0], rand_state[0]};
      rand_state = galois_step(rand_state);
    end
  endtask

  function automatic logic [7:0] lane_next(input logic [7:0] v);
    return {v[6:0], v[7] ^ v[5] ^ v[4] ^ v[3]};
  endfunction

  function automatic logic [31:0] word_next(input logic [31:0] w);
    return {lane_next(w[31:24]), lane_next(w[23:16]), lane_next(w[15:8]), lane_next(w[7:0])};
  endfunction

  // column first, then row, then bank
  function automatic logic [23:0] addr_next(input logic [23:0] a);
    bank_t b;
    row_t  r;
    col_t  c;
    {b, r, c} = a;
    if (c < WIN_COL)
      return {b, r, c + 9'd2};
    else if (r < WIN_ROW)
      return {b, r + 13'd1, 9'd0};
    else if (b < WIN_BANK)
      return {b + 2'd1, 13'd0, 9'd0};
    else
      return '0;
  endfunction

  function automatic logic [31:0] lane_mask(input logic [3:0] b);
    return {{8{b[3]}}, {8{b[2]}}, {8{b[1]}}, {8{b[0]}}};
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected)
    else
    begin
      $display("Fail %s: expected %h, actual %h", name, expected, actual);
      error_count++;
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    assert (cond)
    else
    begin
      $display("%s", what);
      error_count++;
    end
  endtask

  task automatic store_word(input logic [23:0] addr, input logic [31:0] data,
                            input logic [3:0] enables);
    logic [31:0] word;
    word = mem.exists(addr) ? mem[addr] : '0;
    for (int i = 0; i < 4; i++)
    begin
      if (enables[i])
        word[8*i +: 8] = data[8*i +: 8];
    end
    mem[addr] = word;
  endtask

  // --------------------
  // beat handling
  // --------------------
  task automatic handle_accept();
    logic [23:0] addr;
    logic [7:0]  delay;
    logic        is_read;
    int          phase;
    int          beat;
    ret_t        entry;
    addr = {bank_addr, row_addr, col_addr};
    phase = beat_idx / BEATS_PER_PASS;
    beat = beat_idx % BEATS_PER_PASS;
    is_read = (phase == 1) || (phase == 4);
    check_true(read_req == is_read, "request type does not match the current pass");
    check_value("address", exp_addr, addr);
    check_value("test_status", (phase < 2) ? 3'b001 : 3'b010, test_status);
    if (is_read)
    begin
      if (beat == 0)
      begin
        read_word = data_base;
        read_masked = (phase == 4);
        ret_idx = 0;
      end
      random_bits(2, delay);
      entry.data = mem.exists(addr) ? mem[addr] : '0;
      entry.corrupt = corrupt_armed && (addr == corrupt_key);
      entry.due = cycle + 32'd1 + 32'(delay);
      // in order, one word per cycle
      if (entry.due <= last_due)
        entry.due = last_due + 32'd1;
      last_due = entry.due;
      if (entry.corrupt)
        corrupt_armed = 1'b0;
      ret_q.push_back(entry);
    end
    else
    begin
      if (phase == 2)
      begin
        check_value("zero-fill wdata", 32'd0, wdata);
        check_value("zero-fill be", 4'hf, be);
      end
      else
      begin
        if (beat == 0)
          data_base = gen_word;
        check_value("wdata", gen_word, wdata);
        check_value("be", (phase == 3) ? 4'b0001 << (beat % 4) : 4'hf, be);
        gen_word = word_next(gen_word);
      end
      store_word(addr, wdata, be);
      // damage one lane of one word in the second sequence
      if (phase == 0 && beat == CORRUPT_BEAT && complete_count == 1)
      begin
        mem[addr] = mem[addr] ^ (32'hff << (8 * CORRUPT_LANE));
        corrupt_key = addr;
        corrupt_armed = 1'b1;
      end
    end
    exp_addr = (beat == BEATS_PER_PASS - 1) ? '0 : addr_next(exp_addr);
    beat_idx = (beat_idx + 1) % (BEATS_PER_PASS * PHASES);
  endtask

  task automatic handle_return();
    logic [31:0] exp_word;
    exp_word = read_word & (read_masked ? lane_mask(4'b0001 << (ret_idx % 4)) : '1);
    if (ret_corrupt)
    begin
      corrupt_seen = 1'b1;
      watching = 1'b1;
      watch_left = 4;
    end
    else
    begin
      check_value("read data", exp_word, rdata);
    end
    read_word = word_next(read_word);
    ret_idx++;
  endtask

  task automatic track_corruption();
    if (watching)
    begin
      if (!pnf_per_byte[CORRUPT_LANE])
      begin
        watching = 1'b0;
        lane_dropped = 1'b1;
      end
      else if (watch_left == 1)
      begin
        check_true(1'b0, "pnf_per_byte did not flag the corrupted lane within four cycles");
        watching = 1'b0;
      end
      else
      begin
        watch_left--;
      end
    end
    if (persist_dropped)
      check_true(!pnf_persist, "pnf_persist rose again after a failed read");
    else if (corrupt_seen && !pnf_persist)
      persist_dropped = 1'b1;
  endtask

  task automatic handle_complete();
    check_value("test_status at test_complete", 3'b100, test_status);
    check_value("pnf_per_byte at test_complete", 4'hf, pnf_per_byte);
    check_value("pnf_persist at test_complete", corrupt_seen ? 1'b0 : 1'b1, pnf_persist);
    check_true(beat_idx == 0, "test_complete came before the sequence had run all its beats");
    complete_count++;
  endtask

  // controller side, ready and read returns
  always @(posedge clk)
  begin
    logic [7:0] r;
    cycle = cycle + 32'd1;
    random_bits(1, r);
    ready <= r[0];
    if (ret_q.size() > 0 && ret_q[0].due <= cycle)
    begin
      rdata       <= ret_q[0].data;
      rdata_valid <= 1'b1;
      ret_corrupt <= ret_q[0].corrupt;
      void'(ret_q.pop_front());
    end
    else
    begin
      rdata_valid <= 1'b0;
      ret_corrupt <= 1'b0;
    end
  end

  // compare on the falling edge, all DUT outputs settled
  always @(negedge clk)
  begin
    if (reset_n)
    begin
      track_corruption();
      if ((write_req || read_req) && ready)
        handle_accept();
      if (rdata_valid)
        handle_return();
      if (test_complete)
        handle_complete();
    end
  end

  initial
  begin
    int waited;
    int seq;
    clk = 1'b0;
    reset_n = 1'b0;
    ready = 1'b0;
    rdata = '0;
    rdata_valid = 1'b0;
    ret_corrupt = 1'b0;
    rand_state = 16'd67;
    cycle = '0;
    last_due = '0;
    error_count = 0;
    beat_idx = 0;
    complete_count = 0;
    ret_idx = 0;
    watch_left = 0;
    exp_addr = '0;
    corrupt_key = '0;
    gen_word = SEED_WORD;
    data_base = SEED_WORD;
    read_word = SEED_WORD;
    read_masked = 1'b0;
    corrupt_armed = 1'b0;
    corrupt_seen = 1'b0;
    watching = 1'b0;
    lane_dropped = 1'b0;
    persist_dropped = 1'b0;
    timed_out = 1'b0;
    repeat (4) @(posedge clk);
    reset_n <= 1'b1;

    seq = 0;
    while (seq < NUM_SEQUENCES && !timed_out)
    begin
      waited = 0;
      while (complete_count <= seq && waited < SEQ_TIMEOUT)
      begin
        @(posedge clk);
        waited++;
      end
      if (complete_count <= seq)
      begin
        $display("no test_complete pulse within %0d cycles in sequence %0d", SEQ_TIMEOUT,
                 seq + 1);
        timed_out = 1'b1;
      end
      seq++;
    end

    if (!timed_out)
    begin
      check_true(lane_dropped, "the corrupted lane was never flagged on pnf_per_byte");
      check_true(persist_dropped, "pnf_persist did not fall after the corrupted read");
    end
    $display("checks failed: %0d, assertions failed: %0d", error_count,
             u_ddr_test_driver.u_properties.violations);
    if (!timed_out && error_count == 0 && u_ddr_test_driver.u_properties.violations == 0)
      $display("Simulation PASSED");
    else
      $display("Simulation FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: ddr_test_driver.f
design/ddr_test_pkg.sv
design/lane_lfsr.sv
design/pattern_gen.sv
design/addr_gen.sv
design/read_checker.sv
design/test_sequencer.sv
design/ddr_test_driver.sv
bench/ddr_test_driver_properties.sv
bench/ddr_test_driver_tb.sv

// File: Makefile
# Verilator build and run for the ddr traffic generator testbench

VERILATOR   ?= verilator
TOP         ?= ddr_test_driver_tb
FILELIST    ?= ddr_test_driver.f
OBJ_DIR     ?= obj_dir
BUILD_FLAGS ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS  ?= --lint-only --timing -Wall
RUN_FLAGS   ?= +verilator+error+limit+1000
PASS_TEXT   ?= Simulation PASSED

SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(BUILD_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# the run fails unless the pass line shows up in the output
run: build
	./$(SIM_BIN) $(RUN_FLAGS) | awk '{ print } $$0 == "$(PASS_TEXT)" { ok = 1 } END { exit !ok }'

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
